// File: hdl/tex_cache_pkg.sv
package tex_cache_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------
	localparam int addr_x_width   = 12;
	localparam int addr_y_width   = 12;
	localparam int blk_x_size     = 2;
	localparam int blk_y_size     = 2;
	localparam int tag_addr_width = 6;
	localparam int user_width     = 4;

	localparam int blk_x_width = addr_x_width - blk_x_size;
	localparam int blk_y_width = addr_y_width - blk_y_size;

	typedef struct packed {
		logic [user_width-1:0]   user;
		logic                    last;
		logic                    border;
		logic [addr_x_width-1:0] addr_x;
		logic [addr_y_width-1:0] addr_y;
	} tex_req_t;

	typedef struct packed {
		logic                   valid;
		logic [blk_y_width-1:0] blk_y;
		logic [blk_x_width-1:0] blk_x;
	} tag_entry_t;

	typedef struct packed {
		logic [user_width-1:0]     user;
		logic                      last;
		logic                      border;
		logic [tag_addr_width-1:0] tag_addr;
		logic [blk_x_size-1:0]     pix_x;
		logic [blk_y_size-1:0]     pix_y;
		logic [blk_x_width-1:0]    blk_x;
		logic [blk_y_width-1:0]    blk_y;
		logic                      hit;
	} tag_result_t;

	// spreads neighbouring blocks in y over the index space
	function automatic logic [tag_addr_width-1:0] tag_hash(
		input logic [blk_x_width-1:0] blk_x,
		input logic [blk_y_width-1:0] blk_y
	);
		logic [tag_addr_width-1:0] y_low;
		y_low = blk_y[tag_addr_width-1:0];
		return blk_x[tag_addr_width-1:0] ^ {y_low[2:0], y_low[tag_addr_width-1:3]};
	endfunction

endpackage

// File: hdl/tag_ram_if.sv
`timescale 1ns/10ps

interface tag_ram_if #(
	parameter int TAG_ADDR_WIDTH = 6
);

	logic                      en;
	logic                      we;
	logic [TAG_ADDR_WIDTH-1:0] addr;
	tex_cache_pkg::tag_entry_t wdata;
	// old word of the last enabled access
	tex_cache_pkg::tag_entry_t rdata;

	modport requester (
		output en,
		output we,
		output addr,
		output wdata,
		input  rdata
	);

	modport ram (
		input  en,
		input  we,
		input  addr,
		input  wdata,
		output rdata
	);

endinterface

// File: hdl/tag_ram.sv
`timescale 1ns/10ps

module tag_ram #(
	parameter int TAG_ADDR_WIDTH = 6
) (
	input logic      clk,
	tag_ram_if.ram   bus
);

	localparam int depth = 2 ** TAG_ADDR_WIDTH;

	tex_cache_pkg::tag_entry_t mem [depth];

	// all entries start out invalid
	initial begin
		for (int i = 0; i < depth; i++) begin
			mem[i] = '0;
		end
	end

	// --------------------------------------------------
	// read-first single port
	// --------------------------------------------------
	always @(posedge clk) begin
		if (bus.en) begin
			bus.rdata <= mem[bus.addr];
			if (bus.we) begin
				mem[bus.addr] <= bus.wdata;
			end
		end
	end

	a_addr_known: assert property (@(posedge clk)
		bus.en |-> !$isunknown(bus.addr));

endmodule

// File: hdl/pipe_out_buf.sv
`timescale 1ns/10ps

module pipe_out_buf (
	input  logic                        clk,
	input  logic                        reset,

	input  tex_cache_pkg::tag_result_t  s_data,
	input  logic                        s_valid,
	output logic                        s_ready,

	output tex_cache_pkg::tag_result_t  m_data,
	output logic                        m_valid,
	input  logic                        m_ready
);

	tex_cache_pkg::tag_result_t skid_data;
	logic                       skid_valid;
	logic                       out_free;
	logic                       s_take;

	assign out_free = m_ready || !m_valid;
	assign s_take   = s_valid && s_ready;

	// s_ready mirrors an empty skid slot
	always_ff @(posedge clk) begin
		if (reset) begin
			m_valid    <= 1'b0;
			skid_valid <= 1'b0;
			s_ready    <= 1'b0;
		end else if (out_free) begin
			m_valid    <= skid_valid || s_take;
			skid_valid <= 1'b0;
			s_ready    <= 1'b1;
		end else if (s_take) begin
			skid_valid <= 1'b1;
			s_ready    <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (out_free) begin
			m_data <= skid_valid ? skid_data : s_data;
		end
		// output stalled, park the incoming word
		if (!out_free && s_take) begin
			skid_data <= s_data;
		end
	end

	a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
		m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

// File: hdl/tex_cache_tag.sv
`timescale 1ns/10ps

module tex_cache_tag #(
	parameter int ADDR_X_WIDTH   = 12,
	parameter int ADDR_Y_WIDTH   = 12,
	parameter int TAG_ADDR_WIDTH = 6
) (
	input  logic                        clk,
	input  logic                        reset,

	input  logic                        clear_start,
	output logic                        clear_busy,

	input  tex_cache_pkg::tex_req_t     s_req,
	input  logic                        s_valid,
	output logic                        s_ready,

	output tex_cache_pkg::tag_result_t  m_result,
	output logic                        m_valid,
	input  logic                        m_ready
);

	localparam int blk_x_w   = ADDR_X_WIDTH - tex_cache_pkg::blk_x_size;
	localparam int blk_y_w   = ADDR_Y_WIDTH - tex_cache_pkg::blk_y_size;
	localparam int res_tag_w = tex_cache_pkg::tag_addr_width;

	logic                       cke;
	logic                       run;
	logic                       out_ready;

	logic [blk_x_w-1:0]         s_blk_x;
	logic [blk_y_w-1:0]         s_blk_y;
	logic [TAG_ADDR_WIDTH-1:0]  s_tag_addr;
	tex_cache_pkg::tag_result_t s_res;

	// extra msb flags that every index has been issued
	logic [TAG_ADDR_WIDTH:0]    clr_addr;
	logic                       clr_issue;

	logic                       st0_valid;
	logic                       st0_we;
	logic                       st0_clr;
	logic [TAG_ADDR_WIDTH-1:0]  st0_tag_addr;
	tex_cache_pkg::tag_result_t st0_res;

	logic                       st1_valid;
	tex_cache_pkg::tag_result_t st1_res;
	logic                       hit;

	logic                       st2_valid;
	tex_cache_pkg::tag_result_t st2_res;

	tag_ram_if #(.TAG_ADDR_WIDTH(TAG_ADDR_WIDTH)) tag_bus ();

	// --------------------------------------------------
	// address split and hash
	// --------------------------------------------------
	assign s_blk_x    = s_req.addr_x[ADDR_X_WIDTH-1:tex_cache_pkg::blk_x_size];
	assign s_blk_y    = s_req.addr_y[ADDR_Y_WIDTH-1:tex_cache_pkg::blk_y_size];
	assign s_tag_addr = TAG_ADDR_WIDTH'(tex_cache_pkg::tag_hash(s_blk_x, s_blk_y));

	always_comb begin
		s_res          = '0;
		s_res.user     = s_req.user;
		s_res.last     = s_req.last;
		s_res.border   = s_req.border;
		s_res.tag_addr = res_tag_w'(s_tag_addr);
		s_res.pix_x    = s_req.addr_x[tex_cache_pkg::blk_x_size-1:0];
		s_res.pix_y    = s_req.addr_y[tex_cache_pkg::blk_y_size-1:0];
		s_res.blk_x    = s_blk_x;
		s_res.blk_y    = s_blk_y;
	end

	assign cke       = !st2_valid || out_ready;
	assign s_ready   = run && cke && !clear_busy;
	assign clr_issue = cke && clear_busy && !clr_addr[TAG_ADDR_WIDTH];

	// --------------------------------------------------
	// control and clear sweep
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			run        <= 1'b0;
			clear_busy <= 1'b0;
			clr_addr   <= '0;
			st0_valid  <= 1'b0;
			st0_we     <= 1'b0;
			st0_clr    <= 1'b0;
			st1_valid  <= 1'b0;
			st2_valid  <= 1'b0;
		end else begin
			run <= 1'b1;
			if (!clear_busy && clear_start) begin
				clear_busy <= 1'b1;
				clr_addr   <= '0;
			end else if (clr_issue) begin
				clr_addr <= clr_addr + (TAG_ADDR_WIDTH+1)'(1);
			end else if (cke && st0_clr && clr_addr[TAG_ADDR_WIDTH]) begin
				// last invalidate lands on this edge
				clear_busy <= 1'b0;
			end

			if (cke) begin
				st0_valid <= s_valid && s_ready;
				st0_we    <= clr_issue || (s_valid && s_ready && !s_req.border);
				st0_clr   <= clr_issue;
				st1_valid <= st0_valid;
				st2_valid <= st1_valid;
			end
		end
	end

	// --------------------------------------------------
	// payload stages
	// --------------------------------------------------
	assign hit = tag_bus.rdata.valid
		&& tag_bus.rdata.blk_x == st1_res.blk_x
		&& tag_bus.rdata.blk_y == st1_res.blk_y;

	always_ff @(posedge clk) begin
		if (cke) begin
			st0_res      <= s_res;
			st0_tag_addr <= clr_issue ? clr_addr[TAG_ADDR_WIDTH-1:0] : s_tag_addr;
			st1_res      <= st0_res;
			st2_res      <= st1_res;
			st2_res.hit  <= hit;
		end
	end

	// stage 0 owns the ram port, border lookups only read
	assign tag_bus.en    = cke && (st0_valid || st0_we);
	assign tag_bus.we    = st0_we;
	assign tag_bus.addr  = st0_tag_addr;
	assign tag_bus.wdata = '{valid: !st0_clr, blk_y: st0_res.blk_y, blk_x: st0_res.blk_x};

	tag_ram #(
		.TAG_ADDR_WIDTH (TAG_ADDR_WIDTH)
	) i_tag_ram (
		.clk (clk),
		.bus (tag_bus)
	);

	pipe_out_buf i_out_buf (
		.clk     (clk),
		.reset   (reset),
		.s_data  (st2_res),
		.s_valid (st2_valid),
		.s_ready (out_ready),
		.m_data  (m_result),
		.m_valid (m_valid),
		.m_ready (m_ready)
	);

	// a second start during the sweep must not rewind it
	a_clear_no_restart: assert property (@(posedge clk) disable iff (reset)
		clear_busy && clear_start |=> clr_addr >= $past(clr_addr));

endmodule

// File: hdl/tex_cache_top.sv
`timescale 1ns/10ps

module tex_cache_top #(
	parameter int ADDR_X_WIDTH   = 12,
	parameter int ADDR_Y_WIDTH   = 12,
	parameter int TAG_ADDR_WIDTH = 6
) (
	input  logic                                        clk,
	input  logic                                        reset,

	input  logic                                        clear_start,
	output logic                                        clear_busy,

	input  logic [tex_cache_pkg::user_width-1:0]        s_user,
	input  logic                                        s_last,
	input  logic                                        s_border,
	input  logic [ADDR_X_WIDTH-1:0]                     s_addr_x,
	input  logic [ADDR_Y_WIDTH-1:0]                     s_addr_y,
	input  logic                                        s_valid,
	output logic                                        s_ready,

	output logic [tex_cache_pkg::user_width-1:0]        m_user,
	output logic                                        m_last,
	output logic                                        m_border,
	output logic [tex_cache_pkg::tag_addr_width-1:0]    m_tag_addr,
	output logic [tex_cache_pkg::blk_x_size-1:0]        m_pix_x,
	output logic [tex_cache_pkg::blk_y_size-1:0]        m_pix_y,
	output logic [ADDR_X_WIDTH-tex_cache_pkg::blk_x_size-1:0] m_blk_x,
	output logic [ADDR_Y_WIDTH-tex_cache_pkg::blk_y_size-1:0] m_blk_y,
	output logic                                        m_hit,
	output logic                                        m_valid,
	input  logic                                        m_ready
);

	tex_cache_pkg::tex_req_t    s_req;
	tex_cache_pkg::tag_result_t m_result;

	// structs are sized from the package
	if (ADDR_X_WIDTH != tex_cache_pkg::addr_x_width
			|| ADDR_Y_WIDTH != tex_cache_pkg::addr_y_width
			|| TAG_ADDR_WIDTH > tex_cache_pkg::tag_addr_width) begin : g_width_check
		$error("tex_cache_top: address widths disagree with tex_cache_pkg");
	end

	assign s_req = '{user: s_user, last: s_last, border: s_border,
		addr_x: s_addr_x, addr_y: s_addr_y};

	tex_cache_tag #(
		.ADDR_X_WIDTH   (ADDR_X_WIDTH),
		.ADDR_Y_WIDTH   (ADDR_Y_WIDTH),
		.TAG_ADDR_WIDTH (TAG_ADDR_WIDTH)
	) i_tag (
		.clk         (clk),
		.reset       (reset),
		.clear_start (clear_start),
		.clear_busy  (clear_busy),
		.s_req       (s_req),
		.s_valid     (s_valid),
		.s_ready     (s_ready),
		.m_result    (m_result),
		.m_valid     (m_valid),
		.m_ready     (m_ready)
	);

	// --------------------------------------------------
	// result fields
	// --------------------------------------------------
	assign m_user     = m_result.user;
	assign m_last     = m_result.last;
	assign m_border   = m_result.border;
	assign m_tag_addr = m_result.tag_addr;
	assign m_pix_x    = m_result.pix_x;
	assign m_pix_y    = m_result.pix_y;
	assign m_blk_x    = m_result.blk_x;
	assign m_blk_y    = m_result.blk_y;
	assign m_hit      = m_result.hit;

endmodule

// File: bench/tb_tex_cache.sv
`timescale 1ns/10ps

module tb_tex_cache;

	localparam int n_directed = 12;
	localparam int n_random   = 160;
	localparam int n_cleared  = 16;
	localparam int n_resident = n_cleared / 2;
	localparam int n_latency  = 24;
	localparam int n_clears   = 1;
	localparam int limit_ns   = ((n_directed + n_random + n_resident + n_cleared
		+ n_latency) * 20 + n_clears * 200 + 50) * 8;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic        clear_start = 1'b0;
	logic        clear_busy;
	logic [3:0]  s_user = '0;
	logic        s_last = 1'b0;
	logic        s_border = 1'b0;
	logic [11:0] s_addr_x = '0;
	logic [11:0] s_addr_y = '0;
	logic        s_valid = 1'b0;
	logic        s_ready;
	logic [3:0]  m_user;
	logic        m_last;
	logic        m_border;
	logic [5:0]  m_tag_addr;
	logic [1:0]  m_pix_x;
	logic [1:0]  m_pix_y;
	logic [9:0]  m_blk_x;
	logic [9:0]  m_blk_y;
	logic        m_hit;
	logic        m_valid;
	logic        m_ready = 1'b1;

	logic [15:0] req_state = 16'd24;
	logic [15:0] stall_state = 16'd24;
	logic        stall_mode = 1'b0;
	logic        lat_check = 1'b0;
	int          cycle = 0;

	// reference cache
	logic        model_valid [64];
	logic [9:0]  model_bx [64];
	logic [9:0]  model_by [64];

	tex_cache_pkg::tag_result_t exp_q[$];
	int                         acc_q[$];

	tex_cache_top i_dut (.*);

	always #4 clk = !clk;

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	function automatic logic [5:0] index_of(input logic [9:0] bx, input logic [9:0] by);
		return bx[5:0] ^ {by[2:0], by[5:3]};
	endfunction

	task automatic get_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			req_state = lfsr_next(req_state);
			v = {v[30:0], req_state[0]};
		end
	endtask

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic send_req(input logic [11:0] x, input logic [11:0] y,
			input logic [3:0] user, input logic last, input logic border);
		logic ok;
		ok = 1'b0;
		while (!ok) begin
			@(negedge clk);
			s_addr_x = x;
			s_addr_y = y;
			s_user   = user;
			s_last   = last;
			s_border = border;
			s_valid  = 1'b1;
			ok       = s_ready;
			@(posedge clk);
		end
	endtask

	task automatic send_random(input logic border_ok);
		logic [31:0] r;
		get_bits(21, r);
		send_req({6'b0, r[5:0]}, {6'b0, r[11:6]}, r[15:12], r[16],
			border_ok && r[19:17] == 3'b000);
	endtask

	task automatic go_idle();
		@(negedge clk);
		s_valid = 1'b0;
	endtask

	always @(negedge clk) begin
		logic first;
		if (stall_mode) begin
			stall_state = lfsr_next(stall_state);
			first       = stall_state[0];
			stall_state = lfsr_next(stall_state);
			m_ready <= first || stall_state[0];
		end else begin
			m_ready <= 1'b1;
		end
	end

	// --------------------------------------------------
	// model and result checks
	// --------------------------------------------------
	always @(posedge clk) begin
		tex_cache_pkg::tag_result_t e;
		logic [5:0] idx;
		int c;
		cycle++;
		if (m_valid && m_ready) begin
			if (exp_q.size() == 0) begin
				report_fail("a result came out with no request pending");
			end
			e = exp_q.pop_front();
			c = acc_q.pop_front();
			assert (m_user == e.user) else value_error("m_user", 32'(m_user), 32'(e.user));
			assert (m_last == e.last) else value_error("m_last", 32'(m_last), 32'(e.last));
			assert (m_border == e.border)
				else value_error("m_border", 32'(m_border), 32'(e.border));
			assert (m_tag_addr == e.tag_addr)
				else value_error("m_tag_addr", 32'(m_tag_addr), 32'(e.tag_addr));
			assert (m_pix_x == e.pix_x) else value_error("m_pix_x", 32'(m_pix_x), 32'(e.pix_x));
			assert (m_pix_y == e.pix_y) else value_error("m_pix_y", 32'(m_pix_y), 32'(e.pix_y));
			assert (m_blk_x == e.blk_x) else value_error("m_blk_x", 32'(m_blk_x), 32'(e.blk_x));
			assert (m_blk_y == e.blk_y) else value_error("m_blk_y", 32'(m_blk_y), 32'(e.blk_y));
			assert (m_hit == e.hit) else value_error("m_hit", 32'(m_hit), 32'(e.hit));
			// accept edge to output edge
			if (lat_check) begin
				assert (cycle - c == 4) else report_fail("result latency is not 4 clock edges");
			end
		end
		if (s_valid && s_ready) begin
			idx        = index_of(s_addr_x[11:2], s_addr_y[11:2]);
			e          = '0;
			e.user     = s_user;
			e.last     = s_last;
			e.border   = s_border;
			e.tag_addr = idx;
			e.pix_x    = s_addr_x[1:0];
			e.pix_y    = s_addr_y[1:0];
			e.blk_x    = s_addr_x[11:2];
			e.blk_y    = s_addr_y[11:2];
			e.hit      = model_valid[idx] && model_bx[idx] == e.blk_x
				&& model_by[idx] == e.blk_y;
			if (!s_border) begin
				model_valid[idx] = 1'b1;
				model_bx[idx]    = e.blk_x;
				model_by[idx]    = e.blk_y;
			end
			exp_q.push_back(e);
			acc_q.push_back(cycle);
		end
		if (!reset && clear_start && !clear_busy) begin
			for (int i = 0; i < 64; i++) begin
				model_valid[i] = 1'b0;
			end
		end
	end

	a_busy_no_input: assert property (@(posedge clk) disable iff (reset)
		clear_busy |-> !s_ready)
		else report_fail("s_ready was high during the clear sweep");

	a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
		m_valid && !m_ready |=> m_valid && $stable(m_blk_x) && $stable(m_blk_y)
			&& $stable(m_user) && $stable(m_hit) && $stable(m_tag_addr)
			&& $stable(m_last) && $stable(m_border)
			&& $stable(m_pix_x) && $stable(m_pix_y))
		else report_fail("result changed while the output was stalled");

	initial begin
		#(limit_ns);
		$display("watchdog expired before the tests finished");
		$display("Result: FAILED");
		$fatal(1);
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		for (int i = 0; i < 64; i++) begin
			model_valid[i] = 1'b0;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// blocks (4,8) and (5,0) share index 5
		send_req(12'h010, 12'h020, 4'h1, 1'b0, 1'b0);
		send_req(12'h013, 12'h021, 4'h2, 1'b1, 1'b0);
		send_req(12'h014, 12'h000, 4'h3, 1'b0, 1'b0);
		send_req(12'h011, 12'h023, 4'h4, 1'b0, 1'b0);
		send_req(12'h011, 12'h022, 4'h5, 1'b1, 1'b0);
		// border lookups leave the entry alone
		send_req(12'h100, 12'h104, 4'h6, 1'b0, 1'b1);
		send_req(12'h101, 12'h105, 4'h7, 1'b0, 1'b1);
		send_req(12'h102, 12'h106, 4'h8, 1'b0, 1'b0);
		send_req(12'h103, 12'h107, 4'h9, 1'b1, 1'b1);
		send_req(12'h103, 12'h107, 4'ha, 1'b0, 1'b0);
		send_req(12'hffc, 12'hfff, 4'hb, 1'b0, 1'b0);
		send_req(12'hffd, 12'hffe, 4'hc, 1'b1, 1'b0);
		go_idle();

		stall_mode = 1'b1;
		for (int i = 0; i < n_random; i++) begin
			send_random(1'b1);
		end
		go_idle();
		wait (exp_q.size() == 0);
		stall_mode = 1'b0;

		// blocks revisited after the sweep are resident beforehand
		for (int i = 0; i < n_resident; i++) begin
			send_req(12'(i * 4 + 2), 12'h012, 4'(i), 1'b0, 1'b0);
		end
		go_idle();
		wait (exp_q.size() == 0);

		@(negedge clk);
		clear_start = 1'b1;
		@(negedge clk);
		if (!clear_busy) begin
			report_fail("clear_busy did not rise after clear_start");
		end
		// start held into the sweep
		repeat (4) @(negedge clk);
		clear_start = 1'b0;
		wait (!clear_busy);
		for (int i = 0; i < n_cleared / 2; i++) begin
			send_req(12'(i * 4), 12'h010, 4'(i), 1'b0, 1'b0);
			send_req(12'(i * 4 + 1), 12'h011, 4'(i), 1'b1, 1'b0);
		end
		go_idle();
		wait (exp_q.size() == 0);

		lat_check = 1'b1;
		for (int i = 0; i < n_latency; i++) begin
			send_random(1'b0);
		end
		go_idle();
		wait (exp_q.size() == 0);
		repeat (4) @(posedge clk);

		if (exp_q.size() == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
hdl/tex_cache_pkg.sv
hdl/tag_ram_if.sv
hdl/tag_ram.sv
hdl/pipe_out_buf.sv
hdl/tex_cache_tag.sv
hdl/tex_cache_top.sv
bench/tb_tex_cache.sv

// File: run_sim.sh
#!/bin/sh
# build and run the texture cache tag stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_tex_cache \
	-Mdir obj_dir \
	-f src.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_tex_cache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit 1
fi

if echo "$output" | grep -q "Result: PASSED"; then
	exit 0
fi
exit 1
